/* hw/renderPkg.sv */
/*
 * Render package.
 * Shared types, 640x480 video timing, the APB register map and the
 * fixed sprite bitmaps of the raster pixel renderer.
 */
`default_nettype none

package renderPkg;

    // --------------------
    // coordinates.
    localparam int coordBits   = 10;
    localparam int spriteSize  = 8;  // sprite edge in pixels.
    localparam int spriteCount = 4;
    localparam int paletteDepth = 16;

    typedef logic [coordBits-1:0] coordT;

    // horizontal timing, in pixels.
    localparam coordT hActive = 10'd640;
    localparam coordT hFront  = 10'd16;
    localparam coordT hSync   = 10'd96;
    localparam coordT hBack   = 10'd48;
    localparam coordT hTotal  = hActive + hFront + hSync + hBack;

    // vertical timing, in lines.
    localparam coordT vActive = 10'd480;
    localparam coordT vFront  = 10'd10;
    localparam coordT vSync   = 10'd2;
    localparam coordT vBack   = 10'd33;
    localparam coordT vTotal  = vActive + vFront + vSync + vBack;

    localparam int frameCycles = int'(hTotal) * int'(vTotal); // clocks per frame.

    // --------------------
    // register map.
    localparam logic [7:0] regBallPos   = 8'h00;
    localparam logic [7:0] regBallSize  = 8'h04;
    localparam logic [7:0] regBallColor = 8'h08;
    localparam logic [7:0] regSpritePos = 8'h0C;
    localparam logic [7:0] regSpriteId  = 8'h10;
    localparam logic [7:0] regBgColor   = 8'h14;
    localparam logic [7:0] palBase      = 8'h40; // first palette word.
    localparam logic [7:0] palLast      = 8'h7C; // last palette word.

    // --------------------
    // types.
    typedef struct packed {
        coordT x;
        coordT y;
    } pointT;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbT;

    typedef struct packed {
        logic hSyncN;
        logic vSyncN;
        logic de;
    } syncT;

    typedef struct packed {
        logic [7:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRspT;

    typedef struct packed {
        pointT      ballPos;   // centre.
        coordT      ballSize;  // radius.
        rgbT        ballColor;
        pointT      spritePos; // top-left corner.
        logic [1:0] spriteId;
        rgbT        bgColor;
    } sceneT;

    typedef struct packed {
        logic       en;
        logic [3:0] index;
        rgbT        color;
    } palWriteT;

    // blanking state, both syncs released.
    localparam syncT syncIdle = '{hSyncN: 1'b1, vSyncN: 1'b1, de: 1'b0};

    // --------------------
    // sprite bitmaps, indexed [sprite][row][column], 0 is transparent.
    localparam logic [1:0] spriteBitmap [spriteCount][spriteSize][spriteSize] = '{
        '{  // ring.
            '{0, 0, 1, 1, 1, 1, 0, 0},
            '{0, 1, 2, 2, 2, 2, 1, 0},
            '{1, 2, 3, 3, 3, 3, 2, 1},
            '{1, 2, 3, 0, 0, 3, 2, 1},
            '{1, 2, 3, 0, 0, 3, 2, 1},
            '{1, 2, 3, 3, 3, 3, 2, 1},
            '{0, 1, 2, 2, 2, 2, 1, 0},
            '{0, 0, 1, 1, 1, 1, 0, 0}
        },
        '{  // arrow pointing up.
            '{0, 0, 0, 1, 1, 0, 0, 0},
            '{0, 0, 1, 2, 2, 1, 0, 0},
            '{0, 1, 2, 3, 3, 2, 1, 0},
            '{1, 2, 3, 3, 3, 3, 2, 1},
            '{0, 0, 0, 2, 2, 0, 0, 0},
            '{0, 0, 0, 2, 2, 0, 0, 0},
            '{0, 0, 0, 3, 3, 0, 0, 0},
            '{0, 0, 0, 3, 3, 0, 0, 0}
        },
        '{  // diagonal cross.
            '{3, 0, 0, 0, 0, 0, 0, 3},
            '{0, 3, 0, 0, 0, 0, 3, 0},
            '{0, 0, 2, 0, 0, 2, 0, 0},
            '{0, 0, 0, 1, 1, 0, 0, 0},
            '{0, 0, 0, 1, 1, 0, 0, 0},
            '{0, 0, 2, 0, 0, 2, 0, 0},
            '{0, 3, 0, 0, 0, 0, 3, 0},
            '{3, 0, 0, 0, 0, 0, 0, 3}
        },
        '{  // nested frame.
            '{3, 3, 3, 3, 3, 3, 3, 3},
            '{3, 1, 1, 1, 1, 1, 1, 3},
            '{3, 1, 2, 2, 2, 2, 1, 3},
            '{3, 1, 2, 0, 0, 2, 1, 3},
            '{3, 1, 2, 0, 0, 2, 1, 3},
            '{3, 1, 2, 2, 2, 2, 1, 3},
            '{3, 1, 1, 1, 1, 1, 1, 3},
            '{3, 3, 3, 3, 3, 3, 3, 3}
        }
    };

endpackage

`default_nettype wire

/* hw/vgaTiming.sv */
/*
 * VGA timing generator.
 * Free-running pixel and line counters, one pixel per clock, with a
 * registered draw coordinate, active-low syncs and display enable.
 */
`timescale 1ns/1ps
`default_nettype none

module vgaTiming (
    input  logic             clk,
    input  logic             rstN,
    output renderPkg::pointT pos,
    output renderPkg::syncT  sync
);
    import renderPkg::*;

    coordT xNext; // pixel after this one.
    coordT yNext; // its line.

    // --------------------
    // counter wrap.
    always_comb
    begin
        xNext = pos.x + 1'b1;
        yNext = pos.y;
        if (pos.x == hTotal - 1'b1)
        begin
            xNext = '0;  // end of line.
            yNext = (pos.y == vTotal - 1'b1) ? '0 : pos.y + 1'b1;
        end
    end

    // --------------------
    // sync is decoded from the next count so it lines up with pos.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pos.x <= '0;
            pos.y <= vTotal - 1'b1; // last back-porch line, frame starts one line later.
            sync  <= syncIdle;
        end
        else
        begin
            pos.x <= xNext;
            pos.y <= yNext;
            // pulses sit after the front porch.
            sync.hSyncN <= !((xNext >= hActive + hFront) &&
                             (xNext <  hActive + hFront + hSync));
            sync.vSyncN <= !((yNext >= vActive + vFront) &&
                             (yNext <  vActive + vFront + vSync));
            sync.de     <= (xNext < hActive) && (yNext < vActive); // visible area.
        end
    end

endmodule

`default_nettype wire

/* hw/sceneRegs.sv */
/*
 * Scene register block.
 * APB slave with zero wait states holding the ball, sprite and
 * background settings; palette window writes pass on as one-cycle strobes.
 */
`timescale 1ns/1ps
`default_nettype none

module sceneRegs (
    input  logic                clk,
    input  logic                rstN,
    input  renderPkg::apbReqT   apbReq,
    output renderPkg::apbRspT   apbRsp,
    output renderPkg::sceneT    scene,
    output renderPkg::palWriteT palWrite
);
    import renderPkg::*;

    logic access;    // access phase of a selected transfer.
    logic inPalette; // aligned word in the palette window.
    logic mapped;    // address decodes to something.
    logic wrEn;      // write commits at this edge.

    // x in the low half, y from bit 16.
    function automatic logic [31:0] packPoint(pointT p);
        return {6'b0, p.y, 6'b0, p.x};
    endfunction

    assign access    = apbReq.psel && apbReq.penable;
    assign inPalette = (apbReq.paddr >= palBase) && (apbReq.paddr <= palLast) &&
                       (apbReq.paddr[1:0] == 2'b00);
    assign wrEn      = access && apbReq.pwrite && mapped;

    // --------------------
    // decode and read data.
    always_comb
    begin
        mapped        = 1'b1;
        apbRsp.prdata = '0;
        case (apbReq.paddr)
            regBallPos:   apbRsp.prdata = packPoint(scene.ballPos);
            regBallSize:  apbRsp.prdata = {22'b0, scene.ballSize};
            regBallColor: apbRsp.prdata = {8'b0, scene.ballColor};
            regSpritePos: apbRsp.prdata = packPoint(scene.spritePos);
            regSpriteId:  apbRsp.prdata = {30'b0, scene.spriteId};
            regBgColor:   apbRsp.prdata = {8'b0, scene.bgColor};
            default:      mapped = inPalette; // palette reads back as zero.
        endcase
        apbRsp.pready  = 1'b1;              // never stalls.
        apbRsp.pslverr = access && !mapped; // hole in the map.
    end

    // --------------------
    // scene registers.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            scene <= '0; // zero radius, black everywhere.
        else if (wrEn)
        begin
            case (apbReq.paddr)
                regBallPos:
                begin
                    scene.ballPos.x <= apbReq.pwdata[coordBits-1:0];
                    scene.ballPos.y <= apbReq.pwdata[16 +: coordBits];
                end
                regBallSize:  scene.ballSize  <= apbReq.pwdata[coordBits-1:0];
                regBallColor: scene.ballColor <= apbReq.pwdata[23:0];
                regSpritePos:
                begin
                    scene.spritePos.x <= apbReq.pwdata[coordBits-1:0];
                    scene.spritePos.y <= apbReq.pwdata[16 +: coordBits];
                end
                regSpriteId:  scene.spriteId <= apbReq.pwdata[1:0];
                regBgColor:   scene.bgColor  <= apbReq.pwdata[23:0];
                default:      ; // palette words go out on palWrite.
            endcase
        end
    end

    // palette strobe, same edge as the APB access.
    always_comb
    begin
        palWrite.en    = wrEn && inPalette;
        palWrite.index = apbReq.paddr[5:2]; // word number in window.
        palWrite.color = apbReq.pwdata[23:0];
    end

endmodule

`default_nettype wire

/* hw/spritePattern.sv */
/*
 * Sprite pattern lookup.
 * Returns the 2-bit colour index of one sprite at a pixel offset
 * inside its 8x8 box.
 */
`timescale 1ns/1ps
`default_nettype none

module spritePattern (
    input  logic [1:0]       spriteId,
    input  renderPkg::pointT offset,
    output logic [1:0]       colorIndex
);
    import renderPkg::*;

    logic [2:0] col; // column in the box.
    logic [2:0] row; // row in the box.

    // only the low bits matter, the box test is done upstream.
    assign col = offset.x[2:0];
    assign row = offset.y[2:0];

    // bitmap table is fixed at elaboration.
    always_comb
    begin
        colorIndex = spriteBitmap[spriteId][row][col];
    end

endmodule

`default_nettype wire

/* hw/paletteTable.sv */
/*
 * Palette table.
 * Sixteen RGB entries written from the APB side, with one registered
 * read port for the pixel path.
 */
`timescale 1ns/1ps
`default_nettype none

module paletteTable (
    input  logic                clk,
    input  logic                rstN,
    input  renderPkg::palWriteT palWrite,
    input  logic [3:0]          readIndex, // {sprite, colour index}.
    output renderPkg::rgbT      color
);
    import renderPkg::*;

    rgbT entries [paletteDepth]; // four colours per sprite.

    // --------------------
    // write port and registered read.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < paletteDepth; i++)
                entries[i] <= '0; // all black.
            color <= '0;
        end
        else
        begin
            if (palWrite.en)
                entries[palWrite.index] <= palWrite.color;
            color <= entries[readIndex]; // old value on a same-cycle write.
        end
    end

endmodule

`default_nettype wire

/* hw/colorMapper.sv */
/*
 * Color mapper.
 * Two-stage pixel pipeline: ball and sprite hit tests with the palette
 * read in stage 1, priority select of ball, sprite, background in stage 2.
 */
`timescale 1ns/1ps
`default_nettype none

module colorMapper (
    input  logic                clk,
    input  logic                rstN,
    input  renderPkg::pointT    pos,
    input  renderPkg::syncT     syncIn,
    input  renderPkg::sceneT    scene,
    input  renderPkg::palWriteT palWrite,
    output renderPkg::rgbT      rgb,
    output renderPkg::syncT     syncOut
);
    import renderPkg::*;

    int         distX;        // signed, from ball centre.
    int         distY;
    int         distSq;
    int         radiusSq;
    logic       ballOn;
    logic       boxOn;        // inside the sprite box.
    pointT      spriteOffset; // pixel relative to sprite corner.
    logic [1:0] colorIndex;
    rgbT        palColor;     // arrives with stage 1 results.

    // stage 1 registers.
    logic ballHit;
    logic spriteHit;
    syncT syncMid;

    // --------------------
    // hit tests.
    assign distX    = int'(pos.x) - int'(scene.ballPos.x);
    assign distY    = int'(pos.y) - int'(scene.ballPos.y);
    assign distSq   = distX * distX + distY * distY;
    assign radiusSq = int'(scene.ballSize) * int'(scene.ballSize);
    assign ballOn   = distSq <= radiusSq; // edge counts as inside.

    // corner included, corner plus 8 excluded.
    assign boxOn = (int'(pos.x) >= int'(scene.spritePos.x)) &&
                   (int'(pos.x) <  int'(scene.spritePos.x) + spriteSize) &&
                   (int'(pos.y) >= int'(scene.spritePos.y)) &&
                   (int'(pos.y) <  int'(scene.spritePos.y) + spriteSize);

    assign spriteOffset = '{x: pos.x - scene.spritePos.x, y: pos.y - scene.spritePos.y};

    spritePattern pattern (
        .spriteId   (scene.spriteId),
        .offset     (spriteOffset),
        .colorIndex (colorIndex)
    );

    paletteTable palette (
        .clk,
        .rstN,
        .palWrite,
        .readIndex ({scene.spriteId, colorIndex}), // sprite picks its bank.
        .color     (palColor)
    );

    // stage 1.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            ballHit   <= 1'b0;
            spriteHit <= 1'b0;
            syncMid   <= syncIdle;
        end
        else
        begin
            ballHit   <= ballOn;
            spriteHit <= boxOn && (colorIndex != 2'd0); // index 0 is see-through.
            syncMid   <= syncIn;
        end
    end

    // --------------------
    // stage 2, priority select.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            rgb     <= '0;
            syncOut <= syncIdle;
        end
        else
        begin
            syncOut <= syncMid; // same delay as video.
            if (!syncMid.de)
                rgb <= '0;      // blanking.
            else if (ballHit)
                rgb <= scene.ballColor;
            else if (spriteHit)
                rgb <= palColor;
            else
                rgb <= scene.bgColor;
        end
    end

endmodule

`default_nettype wire

/* hw/renderTop.sv */
/*
 * Renderer top level.
 * Connects the timing generator, the APB scene registers and the
 * color mapper to the bus and video ports.
 */
`timescale 1ns/1ps
`default_nettype none

module renderTop (
    input  logic              clk,
    input  logic              rstN,
    input  renderPkg::apbReqT apbReq,
    output renderPkg::apbRspT apbRsp,
    output renderPkg::rgbT    rgb,
    output renderPkg::syncT   sync
);
    import renderPkg::*;

    pointT    drawPos;  // coordinate entering the mapper.
    syncT     drawSync; // sync for that coordinate.
    sceneT    scene;
    palWriteT palWrite;

    // --------------------
    // timing.
    vgaTiming timing (
        .clk,
        .rstN,
        .pos  (drawPos),
        .sync (drawSync)
    );

    // host side.
    sceneRegs regs (
        .clk,
        .rstN,
        .apbReq,
        .apbRsp,
        .scene,
        .palWrite
    );

    // --------------------
    // pixel path, two cycles.
    colorMapper mapper (
        .clk,
        .rstN,
        .pos      (drawPos),
        .syncIn   (drawSync),
        .scene,
        .palWrite,
        .rgb,
        .syncOut  (sync)
    );

endmodule

`default_nettype wire

/* tb/tbRender.sv */
/*
 * Renderer testbench.
 * Drives the APB scene registers of renderTop, follows the output video
 * with a pixel tracker and compares pixels against a reference model.
 */
`timescale 1ns/1ps
`default_nettype none

module tbRender;
    import renderPkg::*;

    localparam int halfPeriod  = 2; // 4 ns clock.
    localparam int clkPeriodNs = 2 * halfPeriod;
    // one frame to the first vsync, seven frames of tests, two spare.
    localparam int watchdogNs  = (4 + spriteCount + 2) * frameCycles * clkPeriodNs;
    localparam logic [7:0]  sceneAddr [6] = '{regBallPos, regBallSize, regBallColor,
                                              regSpritePos, regSpriteId, regBgColor};
    localparam logic [31:0] sceneMask [6] = '{32'h03FF03FF, 32'h3FF, 32'hFFFFFF,
                                              32'h03FF03FF, 32'h3, 32'hFFFFFF};

    logic   clk;
    logic   rstN;
    apbReqT apbReq;
    apbRspT apbRsp;
    rgbT    rgb;
    syncT   sync;

    int    seed = 32'hc0bd;
    string curTest = "none";
    int    errorsAtStart;
    int    errorCount;
    int    checkCount;
    int    testsRun;
    int    testsFailed;

    // scene as written by the tests.
    int  ballX;
    int  ballY;
    int  ballR;
    rgbT ballColor;
    int  sprX;
    int  sprY;
    int  sprId;
    rgbT bgColor;
    rgbT palShadow [paletteDepth];

    // pixel tracker state.
    syncT prevSync = syncIdle;
    logic checkEn  = 1'b0;
    int   trkX;
    int   trkY;
    int   rowCount;
    int   pixelCount;
    int   checkedPixels;
    int   blankCycles; // cycles since de last fell.
    int   winX0;
    int   winX1;
    int   winY0;
    int   winY1;

    renderTop uut (
        .clk,
        .rstN,
        .apbReq,
        .apbRsp,
        .rgb,
        .sync
    );

    always #(halfPeriod) clk = ~clk;

    // --------------------
    // checking and reporting.
    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual)
        begin
            errorCount++;
            $display("** Error [%s] %s: expected %h, actual %h", curTest, what, expected, actual);
        end
    endtask

    task automatic startTest(input string name);
        curTest       = name;
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest();
        testsRun++;
        if (errorCount == errorsAtStart)
            $display("PASS  %s", curTest);
        else
        begin
            testsFailed++;
            $display("FAIL  %s: %0d errors", curTest, errorCount - errorsAtStart);
        end
    endtask

    function automatic int pickBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // --------------------
    // reference model, ball over opaque sprite over background.
    function automatic rgbT expectedColor(input int x, input int y);
        int         dx;
        int         dy;
        logic [1:0] idx;
        dx = x - ballX;
        dy = y - ballY;
        if (dx * dx + dy * dy <= ballR * ballR)
            return ballColor;
        if (x >= sprX && x < sprX + spriteSize && y >= sprY && y < sprY + spriteSize)
        begin
            idx = spriteBitmap[sprId][y - sprY][x - sprX];
            if (idx != 2'd0)
                return palShadow[{2'(sprId), idx}]; // sprite picks the bank.
        end
        return bgColor;
    endfunction

    // --------------------
    // APB driver, inputs change on the falling edge.
    task automatic busTransfer(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic slverr);
        int waits;
        @(negedge clk);
        apbReq.paddr   = addr;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0; // setup phase.
        apbReq.pwrite  = write;
        apbReq.pwdata  = wdata;
        @(negedge clk);
        apbReq.penable = 1'b1;
        waits = 0;
        #1; // response settles in the low half.
        while (!apbRsp.pready && waits < 16)
        begin
            @(negedge clk);
            #1;
            waits++;
        end
        if (!apbRsp.pready)
        begin
            errorCount++;
            $display("[%s] APB transfer to address %h never completed", curTest, addr);
        end
        rdata  = apbRsp.prdata;
        slverr = apbRsp.pslverr;
        @(negedge clk);
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = 1'b0;
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data,
                            input logic expectErr);
        logic [31:0] unused;
        logic        slverr;
        busTransfer(1'b1, addr, data, unused, slverr);
        checkValue($sformatf("pslverr on write to %h", addr), 32'(expectErr), 32'(slverr));
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data,
                           input logic expectErr);
        logic slverr;
        busTransfer(1'b0, addr, 32'h0, data, slverr);
        checkValue($sformatf("pslverr on read of %h", addr), 32'(expectErr), 32'(slverr));
    endtask

    // writes every scene register and keeps the model in step.
    task automatic setScene(input int bx, input int by, input int br, input rgbT bc,
                            input int sx, input int sy, input int sid, input rgbT bg);
        ballX     = bx;
        ballY     = by;
        ballR     = br;
        ballColor = bc;
        sprX      = sx;
        sprY      = sy;
        sprId     = sid;
        bgColor   = bg;
        apbWrite(regBallPos, {6'b0, 10'(by), 6'b0, 10'(bx)}, 1'b0);
        apbWrite(regBallSize, 32'(br), 1'b0);
        apbWrite(regBallColor, {8'b0, bc}, 1'b0);
        apbWrite(regSpritePos, {6'b0, 10'(sy), 6'b0, 10'(sx)}, 1'b0);
        apbWrite(regSpriteId, 32'(sid), 1'b0);
        apbWrite(regBgColor, {8'b0, bg}, 1'b0);
    endtask

    // --------------------
    // pixel tracker on the output sync, sampled mid-cycle.
    always @(negedge clk)
    begin
        if (sync.vSyncN && !prevSync.vSyncN)
        begin
            trkX       = 0; // frame start.
            trkY       = 0;
            rowCount   = 0;
            pixelCount = 0;
        end
        if (sync.de)
        begin
            if (checkEn && trkX >= winX0 && trkX <= winX1 && trkY >= winY0 && trkY <= winY1)
            begin
                checkValue($sformatf("pixel %0d,%0d", trkX, trkY),
                           32'(expectedColor(trkX, trkY)), 32'(rgb));
                checkedPixels++;
            end
            trkX++;
            pixelCount++;
        end
        else
        begin
            if (checkEn)
                checkValue("rgb in blanking", 32'h0, 32'(rgb));
            if (prevSync.de)
            begin
                if (checkEn)
                    checkValue("row length", 32'(hActive), 32'(trkX));
                trkX = 0; // row ended.
                trkY++;
                rowCount++;
                blankCycles = 0;
            end
            // hsync pulse sits after the front porch of each active row.
            if (checkEn && blankCycles < int'(hTotal - hActive))
                checkValue("hSyncN in row blanking",
                           32'(!(blankCycles >= int'(hFront) &&
                                 blankCycles < int'(hFront + hSync))),
                           32'(sync.hSyncN));
            blankCycles++;
        end
        prevSync = sync;
    end

    task automatic waitVsync();
        while (sync.vSyncN)
            @(negedge clk);
    endtask

    // checks one whole frame, pixels inside the window against the model.
    task automatic checkFrame(input int x0, input int x1, input int y0, input int y1,
                              output int checked);
        winX0 = x0;
        winX1 = x1;
        winY0 = y0;
        winY1 = y1;
        while (!sync.vSyncN)
            @(negedge clk); // rest of the pulse.
        checkedPixels = 0;
        checkEn       = 1'b1;
        while (sync.vSyncN)
            @(negedge clk); // back porch, active area, front porch.
        checkEn = 1'b0;
        checked = checkedPixels;
        checkValue("rows per frame", 32'(vActive), 32'(rowCount));
        checkValue("pixels per frame", 32'(int'(hActive) * int'(vActive)), 32'(pixelCount));
    endtask

    // --------------------
    // tests.
    task automatic testReset();
        startTest("reset state");
        @(negedge clk);
        checkValue("hSyncN", 32'd1, 32'(sync.hSyncN));
        checkValue("vSyncN", 32'd1, 32'(sync.vSyncN));
        checkValue("de", 32'd0, 32'(sync.de));
        checkValue("rgb", 32'h0, 32'(rgb));
        checkValue("pslverr", 32'd0, 32'(apbRsp.pslverr));
        finishTest();
    endtask

    task automatic testRegisters();
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] bgBefore;
        startTest("register access");
        waitVsync();
        for (int i = 0; i < 6; i++)
        begin
            wdata = $random(seed);
            apbWrite(sceneAddr[i], wdata, 1'b0);
            apbRead(sceneAddr[i], rdata, 1'b0);
            checkValue($sformatf("readback of %h", sceneAddr[i]), wdata & sceneMask[i], rdata);
        end
        wdata = $random(seed);
        apbWrite(palBase + 8'h08, wdata, 1'b0);
        palShadow[2] = wdata[23:0];
        apbRead(palBase + 8'h08, rdata, 1'b0);
        checkValue("palette readback", 32'h0, rdata); // write only.
        apbRead(regBgColor, bgBefore, 1'b0);
        apbWrite(8'h18, 32'hdeadbeef, 1'b1);      // hole after the scene block.
        apbWrite(palBase + 8'h01, 32'h00123456, 1'b1); // misaligned palette word.
        apbRead(8'h80, rdata, 1'b1);
        apbRead(regBgColor, rdata, 1'b0);
        checkValue("bgColor after unmapped access", bgBefore, rdata);
        finishTest();
    endtask

    task automatic testBackground();
        int checked;
        startTest("background");
        waitVsync();
        setScene(1000, 1000, 0, 24'hffffff, 1000, 1000, 0, 24'($random(seed)));
        checkFrame(0, int'(hActive) - 1, 0, int'(vActive) - 1, checked);
        checkValue("pixels checked", 32'(int'(hActive) * int'(vActive)), 32'(checked));
        finishTest();
    endtask

    task automatic testBall();
        int  r;
        int  bx;
        int  by;
        int  checked;
        rgbT bc;
        startTest("ball");
        r  = 4 + pickBelow(60);
        bx = r + 1 + pickBelow(int'(hActive) - 2 * r - 2); // square plus one stays visible.
        by = r + 1 + pickBelow(int'(vActive) - 2 * r - 2);
        bc = 24'($random(seed));
        waitVsync();
        setScene(bx, by, r, bc, 1000, 1000, 0, ~bc);
        checkFrame(bx - r - 1, bx + r + 1, by - r - 1, by + r + 1, checked);
        checkValue("pixels checked", 32'((2 * r + 3) * (2 * r + 3)), 32'(checked));
        finishTest();
    endtask

    task automatic testSprites();
        int sx;
        int sy;
        int checked;
        startTest("sprites and palette");
        waitVsync();
        for (int i = 0; i < paletteDepth; i++)
        begin
            palShadow[i] = 24'($random(seed));
            apbWrite(palBase + 8'(4 * i), {8'b0, palShadow[i]}, 1'b0);
        end
        for (int id = 0; id < spriteCount; id++)
        begin
            sx = 1 + pickBelow(int'(hActive) - spriteSize - 2);
            sy = 1 + pickBelow(int'(vActive) - spriteSize - 2);
            waitVsync();
            setScene(1000, 1000, 0, 24'h0, sx, sy, id, 24'($random(seed)));
            // one pixel ring around the box catches edge errors.
            checkFrame(sx - 1, sx + spriteSize, sy - 1, sy + spriteSize, checked);
            checkValue($sformatf("pixels checked, sprite %0d", id),
                       32'((spriteSize + 2) * (spriteSize + 2)), 32'(checked));
        end
        finishTest();
    endtask

    task automatic testPriority();
        int  sx;
        int  sy;
        int  checked;
        rgbT bc;
        startTest("priority");
        sx = 4 + pickBelow(int'(hActive) - 16);
        sy = 4 + pickBelow(int'(vActive) - 16);
        bc = 24'($random(seed));
        waitVsync();
        // ball covers the lower right of the nested frame and spills out.
        setScene(sx + 5, sy + 5, 3, bc, sx, sy, 3, ~bc);
        checkFrame(sx - 1, sx + spriteSize, sy - 1, sy + spriteSize, checked);
        checkValue("pixels checked", 32'((spriteSize + 2) * (spriteSize + 2)), 32'(checked));
        finishTest();
    endtask

    // --------------------
    // watchdog.
    initial
    begin
        #(watchdogNs);
        $display("watchdog: run did not finish within %0d ns", watchdogNs);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        clk         = 1'b0;
        rstN        = 1'b0;
        apbReq      = '0;
        errorCount  = 0;
        checkCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        for (int i = 0; i < paletteDepth; i++)
            palShadow[i] = '0; // palette resets to black.
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        testReset();
        testRegisters();
        testBackground();
        testBall();
        testSprites();
        testPriority();
        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hw/renderPkg.sv
hw/vgaTiming.sv
hw/sceneRegs.sv
hw/spritePattern.sv
hw/paletteTable.sv
hw/colorMapper.sv
hw/renderTop.sv
tb/tbRender.sv

/* Makefile */
# Verilator build and run of the renderer testbench.

VERILATOR ?= verilator
TOP       ?= tbRender
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if the pass message appears"
	@echo "  clean  remove the build directory"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJDIR)
